// ==== sim.f ====
verilog/pool_pkg.sv
verilog/pool_scan_counter.sv
verilog/ctrl_pool.sv
verilog/pool_max_row.sv
verilog/pool_top.sv
verif/tb_pool_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --top-module tb_pool_top -f sim.f -o tb_pool_top > build.log 2>&1 \
  && ./obj_dir/tb_pool_top > sim.log 2>&1 \
  || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log && echo "Simulation passed" \
  || { echo "No result found in sim.log"; exit 1; }

// ==== verif/tb_pool_top.sv ====
`timescale 1ns/1ps

module tb_pool_top
  import pool_pkg::*;
;

  // Pixels of all frames for sizing the run limit
  localparam int TOTAL_PIXELS = 64 + 81 + 144 + 36 + 64;
  localparam int CYCLE_LIMIT  = 2 * TOTAL_PIXELS + 200;

  logic   clk;
  logic   xrst;
  logic   in_start;
  logic   in_valid;
  pixel_t in_data;
  size_t  fea_size;
  size_t  pool_size;
  logic   out_start;
  logic   out_valid;
  logic   out_stop;
  pixel_t out_data;

  int seed;
  int cycles;
  int errors;
  int checks;
  int tests_run;
  int tests_passed;

  // Pixels of the frame being sent
  pixel_t frame_pix[$];

  // Expected window maxima with their first and last markers
  pixel_t exp_data[$];
  bit     exp_first[$];
  bit     exp_last[$];

  // Entry popped by the checker
  pixel_t exp_d;
  bit     exp_f;
  bit     exp_l;

  pool_top dut0 (
    .clk       (clk),
    .xrst      (xrst),
    .in_start  (in_start),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .fea_size  (fea_size),
    .pool_size (pool_size),
    .out_start (out_start),
    .out_valid (out_valid),
    .out_stop  (out_stop),
    .out_data  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string what, input int got, input int expected);
    checks++;
    if (got != expected) begin
      errors++;
      $display("Mismatch at time %0t: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  // Largest pixel of window (wx, wy) in the current frame
  function automatic pixel_t window_max(input int fea, input int pool, input int wx,
                                        input int wy);
    int     r;
    int     c;
    pixel_t m;
    pixel_t p;
    m = frame_pix[wy * pool * fea + wx * pool];
    for (r = 0; r < pool; r++) begin
      for (c = 0; c < pool; c++) begin
        p = frame_pix[(wy * pool + r) * fea + wx * pool + c];
        if (p > m) begin
          m = p;
        end
      end
    end
    return m;
  endfunction

  task automatic queue_expected(input int fea, input int pool);
    int nw;
    int wx;
    int wy;
    nw = fea / pool;
    for (wy = 0; wy < nw; wy++) begin
      for (wx = 0; wx < nw; wx++) begin
        exp_data.push_back(window_max(fea, pool, wx, wy));
        exp_first.push_back(wx == 0 && wy == 0);
        exp_last.push_back(wx == nw - 1 && wy == nw - 1);
      end
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Sends one frame with a start pulse on pixel stray_at when that is not negative
  task automatic send_frame(input int fea, input int pool, input bit gaps, input bit negative,
                            input int stray_at);
    int i;
    int g;
    frame_pix.delete();
    for (i = 0; i < fea * fea; i++) begin
      if (negative) begin
        frame_pix.push_back(pixel_t'(-1 - ($random(seed) & 32'h7fff)));
      end else begin
        frame_pix.push_back(pixel_t'($random(seed)));
      end
    end
    queue_expected(fea, pool);

    next_cycle();
    in_start  = 1'b1;
    fea_size  = size_t'(fea);
    pool_size = size_t'(pool);
    for (i = 0; i < fea * fea; i++) begin
      next_cycle();
      in_start = 1'b0;
      if (gaps && (($random(seed) & 3) == 0)) begin
        g = 1 + ($random(seed) & 1);
        in_valid = 1'b0;
        repeat (g) next_cycle();
      end
      in_valid = 1'b1;
      in_data  = frame_pix[i];
      if (i == stray_at) begin
        // Wrong sizes that must not be taken
        in_start  = 1'b1;
        fea_size  = 8'd4;
        pool_size = 8'd2;
      end
    end
    next_cycle();
    in_valid = 1'b0;
    in_start = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_data.size() != 0) begin
      @(negedge clk);
    end
    // A few more cycles to catch extra outputs
    repeat (5) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      tests_passed++;
      $display("Test %0d, %s: ok", tests_run, name);
    end else begin
      $display("Test %0d, %s: failed with %0d errors", tests_run, name,
               errors - errs_before);
    end
  endtask

  // Output checker sampled on the falling edge
  always @(negedge clk) begin
    if (xrst) begin
      if (out_valid) begin
        if (exp_data.size() == 0) begin
          errors++;
          $display("Output at time %0t with no window maximum pending", $time);
        end else begin
          exp_d = exp_data.pop_front();
          exp_f = exp_first.pop_front();
          exp_l = exp_last.pop_front();
          check_value("out_data", int'(out_data), int'(exp_d));
          check_value("out_start", int'(out_start), int'(exp_f));
          check_value("out_stop", int'(out_stop), int'(exp_l));
        end
      end else begin
        check_value("out_start without out_valid", int'(out_start), 0);
        check_value("out_stop without out_valid", int'(out_stop), 0);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run timed out after %0d cycles with %0d window maxima still missing",
               cycles, exp_data.size());
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int errs0;
    seed         = 32'h7c29_da2e;
    cycles       = 0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_passed = 0;
    xrst         = 1'b0;
    in_start     = 1'b0;
    in_valid     = 1'b0;
    in_data      = '0;
    fea_size     = '0;
    pool_size    = '0;

    repeat (10) @(posedge clk);
    #1;
    xrst = 1'b1;

    // Nothing may come out before a start
    errs0 = errors;
    repeat (20) @(negedge clk);
    report_test("idle after reset", errs0);

    errs0 = errors;
    send_frame(8, 2, 1'b0, 1'b0, -1);
    wait_drain();
    report_test("8x8 frame, pool 2, continuous valid", errs0);

    errs0 = errors;
    send_frame(9, 3, 1'b1, 1'b0, -1);
    wait_drain();
    report_test("9x9 frame, pool 3, valid gaps", errs0);

    errs0 = errors;
    send_frame(12, 2, 1'b1, 1'b1, -1);
    wait_drain();
    report_test("12x12 negative frame, pool 2", errs0);

    // Second frame follows right after the first
    errs0 = errors;
    send_frame(6, 2, 1'b0, 1'b0, 15);
    send_frame(8, 4, 1'b1, 1'b0, -1);
    wait_drain();
    report_test("back to back frames with stray start", errs0);

    $display("Tests run %0d, passed %0d, checks %0d, errors %0d", tests_run, tests_passed,
             checks, errors);
    if (errors == 0 && tests_passed == tests_run) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog/pool_top.sv ====
`timescale 1ns/1ps

module pool_top
  import pool_pkg::*;
(
  input  logic   clk,
  input  logic   xrst,
  input  logic   in_start,
  input  logic   in_valid,
  input  pixel_t in_data,
  input  size_t  fea_size,
  input  size_t  pool_size,
  output logic   out_start,
  output logic   out_valid,
  output logic   out_stop,
  output pixel_t out_data
);

  // Controller flags toward the max row
  logic acc_en;
  logic acc_load;
  col_t acc_col;
  logic win_done;
  logic win_first;
  logic win_last;

  ctrl_pool ctrl0 (
    .clk       (clk),
    .xrst      (xrst),
    .in_start  (in_start),
    .in_valid  (in_valid),
    .fea_size  (fea_size),
    .pool_size (pool_size),
    .acc_en    (acc_en),
    .acc_load  (acc_load),
    .acc_col   (acc_col),
    .win_done  (win_done),
    .win_first (win_first),
    .win_last  (win_last)
  );

  pool_max_row row0 (
    .clk       (clk),
    .xrst      (xrst),
    .in_data   (in_data),
    .acc_en    (acc_en),
    .acc_load  (acc_load),
    .acc_col   (acc_col),
    .win_done  (win_done),
    .win_first (win_first),
    .win_last  (win_last),
    .out_start (out_start),
    .out_valid (out_valid),
    .out_stop  (out_stop),
    .out_data  (out_data)
  );

endmodule

// ==== verilog/pool_max_row.sv ====
`timescale 1ns/1ps

module pool_max_row
  import pool_pkg::*;
(
  input  logic   clk,
  input  logic   xrst,
  input  pixel_t in_data,
  input  logic   acc_en,
  input  logic   acc_load,
  input  col_t   acc_col,
  input  logic   win_done,
  input  logic   win_first,
  input  logic   win_last,
  output logic   out_start,
  output logic   out_valid,
  output logic   out_stop,
  output pixel_t out_data
);

  // Pixel delayed to line up with the controller flags
  pixel_t d_data;

  // Partial maxima for one row of windows
  pixel_t row_mem [ROW_DEPTH];

  pixel_t stored;
  pixel_t larger;
  pixel_t new_max;

  always_ff @(posedge clk) begin
    d_data <= in_data;
  end

  assign stored = row_mem[acc_col];

  // Signed compare of the new pixel against the running maximum
  assign larger = (d_data > stored) ? d_data : stored;

  // First pixel of a window starts a fresh maximum
  assign new_max = acc_load ? d_data : larger;

  always_ff @(posedge clk) begin
    if (acc_en) begin
      row_mem[acc_col] <= new_max;
    end
  end

  // Output stream control
  always_ff @(posedge clk) begin
    if (!xrst) begin
      out_valid <= 1'b0;
      out_start <= 1'b0;
      out_stop  <= 1'b0;
    end else begin
      out_valid <= acc_en && win_done;
      out_start <= acc_en && win_done && win_first;
      out_stop  <= acc_en && win_done && win_last;
    end
  end

  // Completed window maximum
  always_ff @(posedge clk) begin
    if (acc_en && win_done) begin
      out_data <= new_max;
    end
  end

endmodule

// ==== verilog/ctrl_pool.sv ====
`timescale 1ns/1ps

module ctrl_pool
  import pool_pkg::*;
(
  input  logic  clk,
  input  logic  xrst,
  input  logic  in_start,
  input  logic  in_valid,
  input  size_t fea_size,
  input  size_t pool_size,
  output logic  acc_en,
  output logic  acc_load,
  output col_t  acc_col,
  output logic  win_done,
  output logic  win_first,
  output logic  win_last
);

  pool_state_t state;

  // Frame configuration held for the whole frame
  size_t r_fea_size;
  size_t r_pool_size;

  // Scan position of the pixel on the input this cycle
  size_t x;
  size_t y;
  size_t exec_x;
  size_t exec_y;
  col_t  col;

  logic  clear;
  logic  accept;
  size_t fea_last;
  size_t pool_last;
  logic  frame_end;
  logic  win_end;

  assign clear  = (state == S_WAIT);
  assign accept = (state == S_ACTIVE) && in_valid;

  assign fea_last  = r_fea_size - size_t'(1);
  assign pool_last = r_pool_size - size_t'(1);

  // Final pixel of the frame
  assign frame_end = (x == fea_last) && (y == fea_last);

  // Bottom right pixel of a window
  assign win_end = (exec_x == pool_last) && (exec_y == pool_last);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_WAIT;
    end else begin
      case (state)
        S_WAIT: begin
          if (in_start) begin
            state <= S_ACTIVE;
          end
        end
        S_ACTIVE: begin
          // A start pulse here is ignored
          if (accept && frame_end) begin
            state <= S_WAIT;
          end
        end
        default: state <= S_WAIT;
      endcase
    end
  end

  // Sizes are only taken at the start of a frame
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_fea_size  <= '0;
      r_pool_size <= '0;
    end else if (state == S_WAIT && in_start) begin
      r_fea_size  <= fea_size;
      r_pool_size <= pool_size;
    end
  end

  pool_scan_counter scan0 (
    .clk       (clk),
    .xrst      (xrst),
    .clear     (clear),
    .step      (accept),
    .fea_size  (r_fea_size),
    .pool_size (r_pool_size),
    .x         (x),
    .y         (y),
    .exec_x    (exec_x),
    .exec_y    (exec_y),
    .col       (col)
  );

  // Per pixel flags, one cycle behind acceptance
  always_ff @(posedge clk) begin
    if (!xrst) begin
      acc_en    <= 1'b0;
      acc_load  <= 1'b0;
      acc_col   <= '0;
      win_done  <= 1'b0;
      win_first <= 1'b0;
      win_last  <= 1'b0;
    end else begin
      acc_en    <= accept;
      acc_load  <= accept && (exec_x == '0) && (exec_y == '0);
      acc_col   <= col;
      win_done  <= accept && win_end;
      win_first <= accept && win_end && (y == pool_last) && (col == '0);
      win_last  <= accept && win_end && frame_end;
    end
  end

endmodule

// ==== verilog/pool_scan_counter.sv ====
`timescale 1ns/1ps

module pool_scan_counter
  import pool_pkg::*;
(
  input  logic  clk,
  input  logic  xrst,
  input  logic  clear,
  input  logic  step,
  input  size_t fea_size,
  input  size_t pool_size,
  output size_t x,
  output size_t y,
  output size_t exec_x,
  output size_t exec_y,
  output col_t  col
);

  size_t fea_last;
  size_t pool_last;
  logic  x_wrap;
  logic  y_wrap;
  logic  exec_x_wrap;
  logic  exec_y_wrap;

  // Last index along a frame side and along a window side
  assign fea_last  = fea_size - size_t'(1);
  assign pool_last = pool_size - size_t'(1);

  assign x_wrap      = (x == fea_last);
  assign y_wrap      = (y == fea_last);
  assign exec_x_wrap = (exec_x == pool_last);
  assign exec_y_wrap = (exec_y == pool_last);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      x      <= '0;
      y      <= '0;
      exec_x <= '0;
      exec_y <= '0;
      col    <= '0;
    end else if (clear) begin
      x      <= '0;
      y      <= '0;
      exec_x <= '0;
      exec_y <= '0;
      col    <= '0;
    end else if (step) begin
      // Offset inside the window along the row
      exec_x <= exec_x_wrap ? size_t'(0) : exec_x + size_t'(1);

      if (x_wrap) begin
        // End of a frame row, so restart the window column scan
        x      <= '0;
        col    <= '0;
        y      <= y_wrap ? size_t'(0) : y + size_t'(1);
        exec_y <= exec_y_wrap ? size_t'(0) : exec_y + size_t'(1);
      end else begin
        x <= x + size_t'(1);
        if (exec_x_wrap) begin
          col <= col + col_t'(1);
        end
      end
    end
  end

endmodule

// ==== verilog/pool_pkg.sv ====
package pool_pkg;

  // Pixel and size widths
  localparam int DWIDTH = 16;
  localparam int LWIDTH = 8;

  // Largest frame side and the smallest pool the row memory is sized for
  localparam int MAX_FEA_SIZE  = 64;
  localparam int MIN_POOL_SIZE = 2;

  // One partial maximum per window column
  localparam int ROW_DEPTH = MAX_FEA_SIZE / MIN_POOL_SIZE;
  localparam int CWIDTH    = $clog2(ROW_DEPTH);

  // Signed pixel value
  typedef logic signed [DWIDTH-1:0] pixel_t;

  // Frame side, pool side and scan positions
  typedef logic [LWIDTH-1:0] size_t;

  // Window column index into the row memory
  typedef logic [CWIDTH-1:0] col_t;

  // Controller states
  typedef enum logic {
    S_WAIT,
    S_ACTIVE
  } pool_state_t;

endpackage
